// ==== include/mmcam_defs_defs.svh ====
`ifndef MMCAM_DEFS_DEFS_SVH
`define MMCAM_DEFS_DEFS_SVH

// entry count, one fire and one valid bit per entry
`define MMCAM_EFV_WIDTH 16

// entry address, log2 of the entry count
`define MMCAM_ADDR_WIDTH 4

// key fields
`define MMCAM_NODE_WIDTH 6
`define MMCAM_GEN_WIDTH 4

// full key word, node followed by generation
`define MMCAM_KEY_WIDTH (`MMCAM_NODE_WIDTH + `MMCAM_GEN_WIDTH)

// operand word
`define MMCAM_DATA_WIDTH 16

`endif

// ==== rtl/mmcam_token_pkg.sv ====
`include "mmcam_defs_defs.svh"

package mmcam_token_pkg;

    // key seen as one raw word by the comparators
    // or as node and generation by the output stage
    typedef union packed {
        logic [`MMCAM_KEY_WIDTH-1:0] raw;
        struct packed {
            logic [`MMCAM_NODE_WIDTH-1:0] node;
            logic [`MMCAM_GEN_WIDTH-1:0]  gen;
        } f;
    } mmcam_key_u;

    // incoming token
    typedef struct packed {
        mmcam_key_u                   key;
        // 1 = right operand
        logic                         lr;
        // 1 = wait for a partner
        logic                         mf;
        logic [`MMCAM_DATA_WIDTH-1:0] data;
    } mmcam_token_t;

    // result toward the execution unit
    typedef struct packed {
        logic [`MMCAM_NODE_WIDTH-1:0] node;
        logic [`MMCAM_GEN_WIDTH-1:0]  gen;
        // 1 = two operands, 0 = single
        logic                         pair;
        logic [`MMCAM_DATA_WIDTH-1:0] ldata;
        logic [`MMCAM_DATA_WIDTH-1:0] rdata;
    } mmcam_result_t;

endpackage

// ==== rtl/mmcam_ctrl_pkg.sv ====
`include "mmcam_defs_defs.svh"

package mmcam_ctrl_pkg;

    // registered memory-access controls from the control block
    typedef struct packed {
        // write staged token into the enabled entry
        logic                         wr_e;
        // read out and free entry addr
        logic                         del;
        logic [`MMCAM_ADDR_WIDTH-1:0] addr;
    } mmcam_ma_t;

    // compare results from the entry array
    typedef struct packed {
        // key hit, already gated by request
        logic [`MMCAM_EFV_WIDTH-1:0] fire;
        // occupied entries
        logic [`MMCAM_EFV_WIDTH-1:0] valid;
    } mmcam_match_t;

endpackage

// ==== rtl/mmcam_entry_array.sv ====
`timescale 1ns/1ps
`include "mmcam_defs_defs.svh"

module mmcam_entry_array (
    input  logic                            CP,
    input  logic                            MR,
    input  logic                            in_valid,
    input  mmcam_token_pkg::mmcam_token_t   in_tok,
    input  logic [`MMCAM_EFV_WIDTH-1:0]     en,
    input  mmcam_ctrl_pkg::mmcam_ma_t       ma,
    output mmcam_ctrl_pkg::mmcam_match_t    match,
    output mmcam_token_pkg::mmcam_token_t   rd_tok,
    output mmcam_token_pkg::mmcam_token_t   stg_tok,
    output logic                            overflow,
    output logic [`MMCAM_ADDR_WIDTH:0]      occupancy
);
    import mmcam_token_pkg::*;

    localparam int EW = `MMCAM_EFV_WIDTH;

    // entry payload
    mmcam_token_t ent [EW];
    logic [EW-1:0] valid_q;
    // token and enable held for the write cycle
    mmcam_token_t stg_q;
    logic [EW-1:0] en_q;
    logic [EW-1:0] fire_c;
    logic [`MMCAM_ADDR_WIDTH:0] cnt_c;

    // one comparator per entry
    always_comb begin
        for (int i = 0; i < EW; i++) begin
            // only a matching request may fire
            fire_c[i] = valid_q[i] && in_valid && in_tok.mf &&
                        (ent[i].key.raw == in_tok.key.raw);
        end
    end

    assign match.fire  = fire_c;
    assign match.valid = valid_q;

    // stage arriving token
    always_ff @(posedge CP) begin
        if (in_valid) begin
            stg_q <= in_tok;
        end
    end

    // enable follows the control register by the same edge
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            en_q <= '0;
        end else begin
            en_q <= en;
        end
    end

    // entry write
    always_ff @(posedge CP) begin
        for (int i = 0; i < EW; i++) begin
            if (ma.wr_e && en_q[i]) begin
                ent[i] <= stg_q;
            end
        end
    end

    // valid bits, set on write, cleared on delete
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < EW; i++) begin
                if (ma.wr_e && en_q[i]) begin
                    valid_q[i] <= 1'b1;
                end else if (ma.del && (ma.addr == i[`MMCAM_ADDR_WIDTH-1:0])) begin
                    valid_q[i] <= 1'b0;
                end
            end
        end
    end

    // write requested but no free slot was found
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            overflow <= 1'b0;
        end else begin
            overflow <= ma.wr_e && (en_q == '0);
        end
    end

    // population count of valid bits
    always_comb begin
        cnt_c = '0;
        for (int i = 0; i < EW; i++) begin
            cnt_c = cnt_c + {{`MMCAM_ADDR_WIDTH{1'b0}}, valid_q[i]};
        end
    end

    assign occupancy = cnt_c;
    // read port for the fired entry
    assign rd_tok  = ent[ma.addr];
    assign stg_tok = stg_q;

endmodule

// ==== rtl/mmcam_or_am_ma.sv ====
`timescale 1ns/1ps
`include "mmcam_defs_defs.svh"

module mmcam_or_am_ma (
    input  logic                            CP,
    input  logic                            MR,
    input  logic                            mf,
    input  logic [`MMCAM_EFV_WIDTH-1:0]     fire,
    input  logic [`MMCAM_EFV_WIDTH-1:0]     valid,
    output logic [`MMCAM_EFV_WIDTH-1:0]     en,
    output mmcam_ctrl_pkg::mmcam_ma_t       ma
);
    localparam int EW = `MMCAM_EFV_WIDTH;
    localparam int AW = `MMCAM_ADDR_WIDTH;

    logic          fire_or;
    logic [AW-1:0] r_addr;
    logic [AW-1:0] w_addr;
    logic          found;

    // fire detection
    assign fire_or = |fire;

    // lowest-index fire wins when several equal keys wait
    always_comb begin
        r_addr = '0;
        // scan downward so the lowest set bit is kept
        for (int i = EW - 1; i >= 0; i--) begin
            if (fire[i]) begin
                r_addr = AW'(i);
            end
        end
    end

    // address manager, lowest free slot
    always_comb begin
        en     = '0;
        w_addr = '0;
        found  = 1'b0;
        // no slot on a fire or without a request
        if (mf && !fire_or) begin
            for (int i = 0; i < EW; i++) begin
                if (!valid[i] && !found) begin
                    en[i]  = 1'b1;
                    w_addr = AW'(i);
                    found  = 1'b1;
                end
            end
        end
        // full table leaves en at zero
    end

    // memory-access control register
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            ma.wr_e <= 1'b0;
            ma.del  <= 1'b0;
            ma.addr <= '0;
        end else if (mf) begin
            if (fire_or) begin
                // read out partner and free it
                ma.wr_e <= 1'b0;
                ma.del  <= 1'b1;
                ma.addr <= r_addr;
            end else begin
                // store and wait
                ma.wr_e <= 1'b1;
                ma.del  <= 1'b0;
                ma.addr <= w_addr;
            end
        end else begin
            // idle or bypass, addr held
            ma.wr_e <= 1'b0;
            ma.del  <= 1'b0;
        end
    end

endmodule

// ==== rtl/mmcam_pair_out.sv ====
`timescale 1ns/1ps
`include "mmcam_defs_defs.svh"

module mmcam_pair_out (
    input  logic                            CP,
    input  logic                            MR,
    input  logic                            in_valid,
    input  mmcam_token_pkg::mmcam_token_t   in_tok,
    input  logic                            del,
    input  mmcam_token_pkg::mmcam_token_t   stg_tok,
    input  mmcam_token_pkg::mmcam_token_t   rd_tok,
    output logic                            out_valid,
    output mmcam_token_pkg::mmcam_result_t  out_res
);
    import mmcam_token_pkg::*;

    // bypass stage to line up with the fire path
    logic          byp_q;
    mmcam_token_t  byp_tok_q;
    mmcam_result_t res_c;

    always_ff @(posedge CP) begin
        if (in_valid && !in_tok.mf) begin
            byp_tok_q <= in_tok;
        end
    end

    always_comb begin
        if (del) begin
            // key taken from the arriving token
            res_c.node = stg_tok.key.f.node;
            res_c.gen  = stg_tok.key.f.gen;
            res_c.pair = 1'b1;
            // lr picks the slot of the arriving operand
            if (stg_tok.lr) begin
                res_c.ldata = rd_tok.data;
                res_c.rdata = stg_tok.data;
            end else begin
                res_c.ldata = stg_tok.data;
                res_c.rdata = rd_tok.data;
            end
        end else begin
            // single operand, left slot only
            res_c.node  = byp_tok_q.key.f.node;
            res_c.gen   = byp_tok_q.key.f.gen;
            res_c.pair  = 1'b0;
            res_c.ldata = byp_tok_q.data;
            res_c.rdata = '0;
        end
    end

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            byp_q     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            byp_q     <= in_valid && !in_tok.mf;
            out_valid <= del || byp_q;
        end
    end

    // result payload, loaded only with a pulse
    always_ff @(posedge CP) begin
        if (del || byp_q) begin
            out_res <= res_c;
        end
    end

endmodule

// ==== rtl/mmcam_top.sv ====
`timescale 1ns/1ps
`include "mmcam_defs_defs.svh"

module mmcam_top (
    input  logic                            CP,
    input  logic                            MR,
    input  logic                            in_valid,
    input  mmcam_token_pkg::mmcam_token_t   in_tok,
    output logic                            out_valid,
    output mmcam_token_pkg::mmcam_result_t  out_res,
    output logic                            overflow,
    output logic [`MMCAM_ADDR_WIDTH:0]      occupancy
);
    import mmcam_token_pkg::*;
    import mmcam_ctrl_pkg::*;

    mmcam_match_t                match;
    mmcam_ma_t                   ma;
    logic [`MMCAM_EFV_WIDTH-1:0] en;
    mmcam_token_t                rd_tok;
    mmcam_token_t                stg_tok;
    // match request, valid token that waits for a partner
    logic                        req;

    assign req = in_valid && in_tok.mf;

    // storage and comparators
    mmcam_entry_array u_array (
        .CP        (CP),
        .MR        (MR),
        .in_valid  (in_valid),
        .in_tok    (in_tok),
        .en        (en),
        .ma        (ma),
        .match     (match),
        .rd_tok    (rd_tok),
        .stg_tok   (stg_tok),
        .overflow  (overflow),
        .occupancy (occupancy)
    );

    // fire, free slot and access control
    mmcam_or_am_ma u_ctrl (
        .CP    (CP),
        .MR    (MR),
        .mf    (req),
        .fire  (match.fire),
        .valid (match.valid),
        .en    (en),
        .ma    (ma)
    );

    mmcam_pair_out u_out (
        .CP        (CP),
        .MR        (MR),
        .in_valid  (in_valid),
        .in_tok    (in_tok),
        .del       (ma.del),
        .stg_tok   (stg_tok),
        .rd_tok    (rd_tok),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

endmodule

// ==== sim/mmcam_chk.sv ====
`timescale 1ns/1ps
`include "mmcam_defs_defs.svh"

module mmcam_chk (
    input logic                         CP,
    input logic                         MR,
    input logic                         in_valid,
    input logic                         mf,
    input logic [`MMCAM_EFV_WIDTH-1:0]  fire,
    input logic [`MMCAM_EFV_WIDTH-1:0]  en,
    input mmcam_ctrl_pkg::mmcam_ma_t    ma
);

    // write and delete never share a cycle
    a_wr_del_excl: assert property (@(posedge CP) disable iff (MR) !(ma.wr_e && ma.del))
        else $error("wr_e and del asserted together");

    // delete only follows a request that hit a waiting entry
    a_del_after_fire: assert property (@(posedge CP) disable iff (MR)
        ma.del |-> $past(mf && (|fire)))
        else $error("del without a fire in the previous cycle");

    // at most one slot enabled
    a_en_onehot: assert property (@(posedge CP) disable iff (MR) $onehot0(en))
        else $error("write enable is not one-hot or zero");

    // no forwarding path, so inputs need an idle cycle between them
    a_in_spacing: assert property (@(posedge CP) disable iff (MR) in_valid |=> !in_valid)
        else $error("in_valid high on two consecutive cycles");

endmodule

// control block ports seen through the top-level wires that drive them
bind mmcam_top mmcam_chk u_chk (
    .CP       (CP),
    .MR       (MR),
    .in_valid (in_valid),
    .mf       (req),
    .fire     (match.fire),
    .en       (en),
    .ma       (ma)
);

// ==== sim/mmcam_tb.sv ====
`timescale 1ns/1ps
`include "mmcam_defs_defs.svh"

module mmcam_tb;
    import mmcam_token_pkg::*;

    localparam int EW  = `MMCAM_EFV_WIDTH;
    localparam int OW  = `MMCAM_ADDR_WIDTH + 1;
    localparam int NW  = `MMCAM_NODE_WIDTH;
    localparam int GW  = `MMCAM_GEN_WIDTH;
    localparam int DW  = `MMCAM_DATA_WIDTH;
    localparam int TMO = 20;

    logic          CP;
    logic          MR;
    logic          in_valid;
    mmcam_token_t  in_tok;
    logic          out_valid;
    mmcam_result_t out_res;
    logic          overflow;
    logic [OW-1:0] occupancy;

    // shadow of the entry table
    logic          sh_valid [EW];
    mmcam_token_t  sh_tok [EW];

    integer seed;
    int     errs;
    int     n_pass;
    int     n_fail;

    mmcam_top uut (
        .CP        (CP),
        .MR        (MR),
        .in_valid  (in_valid),
        .in_tok    (in_tok),
        .out_valid (out_valid),
        .out_res   (out_res),
        .overflow  (overflow),
        .occupancy (occupancy)
    );

    always #5 CP = ~CP;

    function automatic mmcam_token_t make_tok(input logic [NW-1:0] node,
            input logic [GW-1:0] gen, input logic lr, input logic mf,
            input logic [DW-1:0] data);
        mmcam_token_t t;
        t.key.f.node = node;
        t.key.f.gen  = gen;
        t.lr         = lr;
        t.mf         = mf;
        t.data       = data;
        return t;
    endfunction

    function automatic logic [DW-1:0] rnd_data();
        return DW'($random(seed));
    endfunction

    // predicts with the shadow and checks one token end to end
    task automatic send_check(input mmcam_token_t tok, input string name);
        mmcam_result_t exp_res;
        logic          exp_out;
        logic          exp_ovf;
        logic          got;
        logic          ovf_seen;
        int            hit;
        int            free;
        int            cnt;
        int            cyc;
        int            win;
        exp_res  = '0;
        exp_out  = 1'b0;
        exp_ovf  = 1'b0;
        hit      = -1;
        free     = -1;
        exp_res.node = tok.key.f.node;
        exp_res.gen  = tok.key.f.gen;
        if (!tok.mf) begin
            // bypass result has a single operand on the left
            exp_out       = 1'b1;
            exp_res.ldata = tok.data;
        end else begin
            // lowest-index equal key fires or the token takes the lowest free slot
            for (int i = 0; i < EW; i++) begin
                if (hit < 0 && sh_valid[i] && sh_tok[i].key.raw == tok.key.raw) begin
                    hit = i;
                end
                if (free < 0 && !sh_valid[i]) begin
                    free = i;
                end
            end
            if (hit >= 0) begin
                exp_out      = 1'b1;
                exp_res.pair = 1'b1;
                exp_res.ldata = tok.lr ? sh_tok[hit].data : tok.data;
                exp_res.rdata = tok.lr ? tok.data : sh_tok[hit].data;
                sh_valid[hit] = 1'b0;
            end else if (free >= 0) begin
                sh_valid[free] = 1'b1;
                sh_tok[free]   = tok;
            end else begin
                exp_ovf = 1'b1;
            end
        end
        cnt = 0;
        for (int i = 0; i < EW; i++) begin
            if (sh_valid[i]) begin
                cnt++;
            end
        end
        @(posedge CP);
        #1;
        in_valid = 1'b1;
        in_tok   = tok;
        @(posedge CP);
        #1;
        in_valid = 1'b0;
        got      = 1'b0;
        ovf_seen = 1'b0;
        cyc      = 0;
        // silent tokens are watched over a short fixed window
        win      = exp_out ? TMO : 3;
        while (!got && cyc < win) begin
            @(posedge CP);
            #1;
            if (out_valid) begin
                got = 1'b1;
            end
            if (overflow) begin
                ovf_seen = 1'b1;
            end
            cyc++;
        end
        if (exp_out && !got) begin
            $display("timeout in %s: no result pulse within %0d cycles", name, TMO);
            errs++;
        end else if (!exp_out && got) begin
            $display("error in %s: result pulse for a token that should not produce one",
                     name);
            errs++;
        end else if (got && out_res !== exp_res) begin
            $display("FAIL %s: result expected %h actual %h", name, exp_res, out_res);
            errs++;
        end
        // pulse seen one edge after the sampling edge means two cycles from the drive
        if (got && cyc != 1) begin
            $display("FAIL %s: latency expected 2 actual %0d", name, cyc + 1);
            errs++;
        end
        if (ovf_seen !== exp_ovf) begin
            $display("FAIL %s: overflow expected %b actual %b", name, exp_ovf, ovf_seen);
            errs++;
        end
        if (occupancy !== OW'(cnt)) begin
            $display("FAIL %s: occupancy expected %0d actual %0d", name, cnt, occupancy);
            errs++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errs == 0) begin
            $display("test %s: ok", name);
            n_pass++;
        end else begin
            $display("test %s: %0d errors", name, errs);
            n_fail++;
        end
        errs = 0;
    endtask

    task automatic bypass_single();
        send_check(make_tok(NW'(7), GW'(3), 1'b0, 1'b0, rnd_data()), "bypass");
        finish_test("bypass");
    endtask

    task automatic left_then_right();
        send_check(make_tok(NW'(3), GW'(1), 1'b0, 1'b1, rnd_data()), "left_first");
        send_check(make_tok(NW'(3), GW'(1), 1'b1, 1'b1, rnd_data()), "left_first");
        finish_test("left_first");
    endtask

    task automatic right_then_left();
        send_check(make_tok(NW'(9), GW'(5), 1'b1, 1'b1, rnd_data()), "right_first");
        send_check(make_tok(NW'(9), GW'(5), 1'b0, 1'b1, rnd_data()), "right_first");
        finish_test("right_first");
    endtask

    task automatic fill_and_overflow();
        // 16 distinct keys on nodes 8 to 23
        for (int i = 0; i < EW; i++) begin
            send_check(make_tok(NW'(i + 8), GW'(2), 1'b0, 1'b1, rnd_data()), "full_table");
        end
        send_check(make_tok(NW'(60), GW'(2), 1'b0, 1'b1, rnd_data()), "full_table");
        // partner of entry 5
        send_check(make_tok(NW'(13), GW'(2), 1'b1, 1'b1, rnd_data()), "full_table");
        // new key lands in the freed slot and its partner fires
        send_check(make_tok(NW'(61), GW'(6), 1'b0, 1'b1, rnd_data()), "full_table");
        send_check(make_tok(NW'(61), GW'(6), 1'b1, 1'b1, rnd_data()), "full_table");
        // drain the rest
        for (int i = 0; i < EW; i++) begin
            if (i != 5) begin
                send_check(make_tok(NW'(i + 8), GW'(2), 1'b1, 1'b1, rnd_data()),
                           "full_table");
            end
        end
        finish_test("full_table");
    endtask

    task automatic random_tokens();
        logic [NW-1:0] node;
        logic [GW-1:0] gen;
        logic          lr;
        logic          mf;
        for (int n = 0; n < 40; n++) begin
            // small key set so fires are frequent
            node = NW'({$random(seed)} % 3 + 1);
            gen  = GW'({$random(seed)} % 2);
            lr   = ({$random(seed)} % 2) != 0;
            mf   = ({$random(seed)} % 5) != 0;
            send_check(make_tok(node, gen, lr, mf, rnd_data()), "random");
        end
        finish_test("random");
    endtask

    initial begin
        seed     = 81140;
        errs     = 0;
        n_pass   = 0;
        n_fail   = 0;
        CP       = 1'b0;
        MR       = 1'b1;
        in_valid = 1'b0;
        in_tok   = '0;
        for (int i = 0; i < EW; i++) begin
            sh_valid[i] = 1'b0;
            sh_tok[i]   = '0;
        end
        repeat (10) @(posedge CP);
        #1;
        MR = 1'b0;

        bypass_single();
        left_then_right();
        right_then_left();
        fill_and_overflow();
        random_tokens();

        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/mmcam_token_pkg.sv
rtl/mmcam_ctrl_pkg.sv
rtl/mmcam_entry_array.sv
rtl/mmcam_or_am_ma.sv
rtl/mmcam_pair_out.sv
rtl/mmcam_top.sv
sim/mmcam_chk.sv
sim/mmcam_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the matching-memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mmcam_tb -f vlog.f -o mmcam_sim

./obj_dir/mmcam_sim | tee sim.log

if ! grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation did not pass, see sim.log"
    exit 1
fi
